// ==== include/branch_detect_defs.svh ====
`ifndef BRANCH_DETECT_DEFS_SVH
`define BRANCH_DETECT_DEFS_SVH

// instruction slots per packet
`define BD_SLOTS 8

// slot index width, log2 of BD_SLOTS
`define BD_IDX_W 3

// operand and pc width
`define BD_XLEN 32

// dependence tag width
`define BD_DEP_W 4

// tag value for an operand read from the register file
`define BD_DEP_NONE ({`BD_DEP_W{1'b1}})

// branch offset width, sign extended before the add
`define BD_IMM_W 16

`endif

// ==== logic/branch_pkg.sv ====
`include "branch_detect_defs.svh"

package branch_pkg;

  // only OP_BJP is a branch
  typedef enum logic [2:0] {
    OP_ALU   = 3'd0,
    OP_LOAD  = 3'd1,
    OP_STORE = 3'd2,
    OP_BJP   = 3'd3
  } opcode_e;

  // LT and GE compare signed
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_JAL = 3'd4
  } br_cond_e;

  // all zero is the nop
  typedef struct packed {
    opcode_e                opcode;
    br_cond_e               cond;
    logic [`BD_DEP_W-1:0]   dep_l;
    logic [`BD_DEP_W-1:0]   dep_r;
    logic [`BD_XLEN-1:0]    pc;
    logic [`BD_IMM_W-1:0]   imm;
  } inst_t;

  typedef struct packed {
    logic [`BD_XLEN-1:0] left;
    logic [`BD_XLEN-1:0] right;
  } opnd_t;

  typedef inst_t [`BD_SLOTS-1:0] packet_t;
  typedef opnd_t [`BD_SLOTS-1:0] opnd_pkt_t;

  typedef struct packed {
    logic [`BD_SLOTS-1:0] mask;
    logic [`BD_IDX_W:0]   count;
    logic [`BD_IDX_W-1:0] first;
  } scan_t;

  // one issue group, slots seg_start..seg_end
  typedef struct packed {
    logic [`BD_IDX_W-1:0] seg_start;
    logic [`BD_IDX_W-1:0] seg_end;
    logic                 taken;
    logic [`BD_XLEN-1:0]  target;
    logic                 last;
  } step_t;

  typedef enum logic {
    WALK_IDLE = 1'b0,
    WALK_RUN  = 1'b1
  } walk_state_e;

endpackage

// ==== logic/branch_scan.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module branch_scan (
  input  logic                  rstn,
  input  logic                  w_IssueFifoFire_1,
  input  logic                  i_pkt_valid,
  input  branch_pkg::packet_t   i_pkt,
  input  branch_pkg::opnd_pkt_t i_grf_opnd,
  input  branch_pkg::opnd_pkt_t i_byp_opnd,
  output logic                  o_scan_valid,
  output branch_pkg::scan_t     o_scan,
  output branch_pkg::packet_t   o_pkt,
  output branch_pkg::opnd_pkt_t o_grf_opnd,
  output branch_pkg::opnd_pkt_t o_byp_opnd
);
  import branch_pkg::*;

  // halving search, keeps the lower half whenever it holds a set bit
  function automatic logic [`BD_IDX_W-1:0] first_set(input logic [`BD_SLOTS-1:0] m);
    logic [`BD_SLOTS-1:0] win;
    logic [`BD_SLOTS-1:0] lo;
    logic [`BD_IDX_W-1:0] idx;
    int                   w;
    win = m;
    idx = '0;
    for (int lvl = `BD_IDX_W - 1; lvl >= 0; lvl--) begin
      w = 1 << lvl;
      lo = win & ~({`BD_SLOTS{1'b1}} << w);
      if (lo == '0) begin
        idx[lvl] = 1'b1;
        win = win >> w;
      end else begin
        win = lo;
      end
    end
    return (|m) ? idx : '0;
  endfunction

  scan_t scan_d;

  always_comb begin
    scan_d.count = '0;
    for (int i = 0; i < `BD_SLOTS; i++) begin
      scan_d.mask[i] = (i_pkt[i].opcode == OP_BJP);
      scan_d.count = scan_d.count + {{`BD_IDX_W{1'b0}}, scan_d.mask[i]};
    end
    scan_d.first = first_set(scan_d.mask);
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_scan_valid <= 1'b0;
    end else begin
      o_scan_valid <= i_pkt_valid;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (i_pkt_valid) begin
      o_scan     <= scan_d;
      o_pkt      <= i_pkt;
      o_grf_opnd <= i_grf_opnd;
      o_byp_opnd <= i_byp_opnd;
    end
  end

endmodule

// ==== logic/branch_resolve.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module branch_resolve (
  input  branch_pkg::inst_t    i_inst,
  input  branch_pkg::opnd_t    i_grf,
  input  branch_pkg::opnd_t    i_byp,
  output logic                 o_taken,
  output logic [`BD_XLEN-1:0]  o_target
);
  import branch_pkg::*;

  logic [`BD_XLEN-1:0] opnd_l;
  logic [`BD_XLEN-1:0] opnd_r;

  // any tag other than none means a bypass value is pending
  assign opnd_l = (i_inst.dep_l == `BD_DEP_NONE) ? i_grf.left  : i_byp.left;
  assign opnd_r = (i_inst.dep_r == `BD_DEP_NONE) ? i_grf.right : i_byp.right;

  always_comb begin
    case (i_inst.cond)
      BR_EQ:   o_taken = (opnd_l == opnd_r);
      BR_NE:   o_taken = (opnd_l != opnd_r);
      BR_LT:   o_taken = ($signed(opnd_l) <  $signed(opnd_r));
      BR_GE:   o_taken = ($signed(opnd_l) >= $signed(opnd_r));
      BR_JAL:  o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  // pc relative target
  assign o_target = i_inst.pc +
                    {{(`BD_XLEN - `BD_IMM_W){i_inst.imm[`BD_IMM_W-1]}}, i_inst.imm};

endmodule

// ==== logic/branch_walker.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module branch_walker (
  input  logic                  rstn,
  input  logic                  w_IssueFifoFire_1,
  input  logic                  i_scan_valid,
  input  branch_pkg::scan_t     i_scan,
  input  branch_pkg::packet_t   i_pkt,
  input  branch_pkg::opnd_pkt_t i_grf_opnd,
  input  branch_pkg::opnd_pkt_t i_byp_opnd,
  output logic                  o_step_valid,
  output branch_pkg::step_t     o_step
);
  import branch_pkg::*;

  localparam logic [`BD_IDX_W-1:0] LAST_IDX = {`BD_IDX_W{1'b1}};

  walk_state_e          state;
  logic [`BD_SLOTS-1:0] rem_mask;
  logic [`BD_IDX_W-1:0] cur_idx;
  logic [`BD_IDX_W-1:0] seg_start;
  logic [`BD_IDX_W:0]   rem_cnt;

  logic                 br_taken;
  logic [`BD_XLEN-1:0]  br_target;
  logic [`BD_SLOTS-1:0] mask_next;
  logic [`BD_IDX_W-1:0] next_idx;
  logic                 have_br;
  logic                 br_last;
  step_t                step_d;

  branch_resolve branch_resolve_i (
    .i_inst   (i_pkt[cur_idx]),
    .i_grf    (i_grf_opnd[cur_idx]),
    .i_byp    (i_byp_opnd[cur_idx]),
    .o_taken  (br_taken),
    .o_target (br_target)
  );

  assign have_br = (rem_cnt != '0);
  assign mask_next = rem_mask & ~({{(`BD_SLOTS-1){1'b0}}, 1'b1} << cur_idx);
  // taken, or the final branch sits in the last slot
  assign br_last = br_taken || ((rem_cnt == {{`BD_IDX_W{1'b0}}, 1'b1}) && (cur_idx == LAST_IDX));

  always_comb begin
    next_idx = '0;
    for (int i = `BD_SLOTS - 1; i >= 0; i--) begin
      if (mask_next[i]) begin
        next_idx = i[`BD_IDX_W-1:0];
      end
    end
  end

  always_comb begin
    step_d.seg_start = seg_start;
    if (have_br) begin
      step_d.seg_end = cur_idx;
      step_d.taken   = br_taken;
      step_d.target  = br_target;
      step_d.last    = br_last;
    end else begin
      // trailing group after the last not-taken branch
      step_d.seg_end = LAST_IDX;
      step_d.taken   = 1'b0;
      step_d.target  = '0;
      step_d.last    = 1'b1;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      state        <= WALK_IDLE;
      rem_mask     <= '0;
      cur_idx      <= '0;
      seg_start    <= '0;
      rem_cnt      <= '0;
      o_step_valid <= 1'b0;
    end else begin
      case (state)
        WALK_IDLE: begin
          o_step_valid <= 1'b0;
          if (i_scan_valid) begin
            rem_mask  <= i_scan.mask;
            cur_idx   <= i_scan.first;
            rem_cnt   <= i_scan.count;
            seg_start <= '0;
            state     <= WALK_RUN;
          end
        end
        WALK_RUN: begin
          o_step_valid <= 1'b1;
          if (have_br) begin
            rem_mask  <= mask_next;
            cur_idx   <= next_idx;
            rem_cnt   <= rem_cnt - 1'b1;
            seg_start <= cur_idx + 1'b1;
            if (br_last) begin
              state <= WALK_IDLE;
            end
          end else begin
            state <= WALK_IDLE;
          end
        end
        default: state <= WALK_IDLE;
      endcase
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (state == WALK_RUN) begin
      o_step <= step_d;
    end
  end

endmodule

// ==== logic/issue_group_builder.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module issue_group_builder (
  input  logic                 rstn,
  input  logic                 w_IssueFifoFire_1,
  input  logic                 i_step_valid,
  input  branch_pkg::step_t    i_step,
  input  branch_pkg::packet_t  i_pkt,
  output logic                 o_issue_valid,
  output branch_pkg::packet_t  o_issue_group,
  output logic                 o_redirect_valid,
  output logic [`BD_XLEN-1:0]  o_redirect_pc,
  output logic                 o_pkt_done
);
  import branch_pkg::*;

  packet_t group_d;

  // slots outside the segment become nops
  always_comb begin
    for (int i = 0; i < `BD_SLOTS; i++) begin
      if ((i[`BD_IDX_W-1:0] >= i_step.seg_start) && (i[`BD_IDX_W-1:0] <= i_step.seg_end)) begin
        group_d[i] = i_pkt[i];
      end else begin
        group_d[i] = '0;
      end
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_issue_valid    <= 1'b0;
      o_redirect_valid <= 1'b0;
      o_pkt_done       <= 1'b0;
      o_issue_group    <= '0;
      o_redirect_pc    <= '0;
    end else begin
      o_issue_valid    <= i_step_valid;
      o_redirect_valid <= i_step_valid && i_step.taken;
      o_pkt_done       <= i_step_valid && i_step.last;
      if (i_step_valid) begin
        o_issue_group <= group_d;
      end
      // fetch redirect holds until the next taken branch
      if (i_step_valid && i_step.taken) begin
        o_redirect_pc <= i_step.target;
      end
    end
  end

endmodule

// ==== logic/branch_detect_top.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module branch_detect_top (
  input  logic                  rstn,
  input  logic                  w_IssueFifoFire_1,
  input  logic                  i_pkt_valid,
  input  branch_pkg::packet_t   i_pkt,
  input  branch_pkg::opnd_pkt_t i_grf_opnd,
  input  branch_pkg::opnd_pkt_t i_byp_opnd,
  output logic                  o_issue_valid,
  output branch_pkg::packet_t   o_issue_group,
  output logic                  o_redirect_valid,
  output logic [`BD_XLEN-1:0]   o_redirect_pc,
  output logic                  o_pkt_done
);
  import branch_pkg::*;

  logic      scan_valid;
  scan_t     scan;
  packet_t   pkt_q;
  opnd_pkt_t grf_q;
  opnd_pkt_t byp_q;
  logic      step_valid;
  step_t     step;

  // decode stage
  branch_scan branch_scan_i (
    .rstn              (rstn),
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .i_pkt_valid       (i_pkt_valid),
    .i_pkt             (i_pkt),
    .i_grf_opnd        (i_grf_opnd),
    .i_byp_opnd        (i_byp_opnd),
    .o_scan_valid      (scan_valid),
    .o_scan            (scan),
    .o_pkt             (pkt_q),
    .o_grf_opnd        (grf_q),
    .o_byp_opnd        (byp_q)
  );

  // execute stage
  branch_walker branch_walker_i (
    .rstn              (rstn),
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .i_scan_valid      (scan_valid),
    .i_scan            (scan),
    .i_pkt             (pkt_q),
    .i_grf_opnd        (grf_q),
    .i_byp_opnd        (byp_q),
    .o_step_valid      (step_valid),
    .o_step            (step)
  );

  // result stage
  issue_group_builder issue_group_builder_i (
    .rstn              (rstn),
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .i_step_valid      (step_valid),
    .i_step            (step),
    .i_pkt             (pkt_q),
    .o_issue_valid     (o_issue_valid),
    .o_issue_group     (o_issue_group),
    .o_redirect_valid  (o_redirect_valid),
    .o_redirect_pc     (o_redirect_pc),
    .o_pkt_done        (o_pkt_done)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rstn
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // release away from the rising edge
  initial begin
    o_rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rstn = 1'b1;
  end

endmodule

// ==== tb/branch_detect_tb.sv ====
`timescale 1ns/1ps
`include "branch_detect_defs.svh"

module branch_detect_tb;
  import branch_pkg::*;

  localparam int RAND_PKTS = 40;
  localparam int PKT_GAP   = `BD_SLOTS + 3;
  // 15 directed packets plus the random ones, idle cycles per test, reset, margin
  localparam int CYCLE_LIMIT = (15 + RAND_PKTS) * PKT_GAP + 5 * 2 + 60;
  localparam logic [`BD_DEP_W-1:0] DEP_NONE = `BD_DEP_NONE;

  // one predicted output cycle
  typedef struct packed {
    logic                valid;
    packet_t             group;
    logic                redirect;
    logic [`BD_XLEN-1:0] pc;
    logic                done;
  } issue_exp_t;

  logic                w_IssueFifoFire_1;
  logic                rstn;
  logic                pkt_valid;
  packet_t             pkt;
  opnd_pkt_t           grf_opnd;
  opnd_pkt_t           byp_opnd;
  logic                issue_valid;
  packet_t             issue_group;
  logic                redirect_valid;
  logic [`BD_XLEN-1:0] redirect_pc;
  logic                pkt_done;

  packet_t             pkt_v;
  opnd_pkt_t           grf_v;
  opnd_pkt_t           byp_v;
  issue_exp_t          exp_q[$];
  int                  exp_edge_q[$];
  issue_exp_t          exp_now;
  int                  cyc = 0;
  int                  err_cnt = 0;
  int                  test_cnt = 0;
  int                  fail_cnt = 0;
  int                  err_mark = 0;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) clock_gen_i (
    .o_clk  (w_IssueFifoFire_1),
    .o_rstn (rstn)
  );

  branch_detect_top branch_detect_top_i (
    .rstn              (rstn),
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .i_pkt_valid       (pkt_valid),
    .i_pkt             (pkt),
    .i_grf_opnd        (grf_opnd),
    .i_byp_opnd        (byp_opnd),
    .o_issue_valid     (issue_valid),
    .o_issue_group     (issue_group),
    .o_redirect_valid  (redirect_valid),
    .o_redirect_pc     (redirect_pc),
    .o_pkt_done        (pkt_done)
  );

  always @(posedge w_IssueFifoFire_1) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  // expected outputs for the cycle after this edge
  // group and pc hold between groups like the DUT
  always @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      exp_now <= '0;
    end else if ((exp_edge_q.size() != 0) && (exp_edge_q[0] == cyc + 1)) begin
      exp_now.valid    <= exp_q[0].valid;
      exp_now.group    <= exp_q[0].group;
      exp_now.redirect <= exp_q[0].redirect;
      exp_now.done     <= exp_q[0].done;
      if (exp_q[0].redirect) begin
        exp_now.pc <= exp_q[0].pc;
      end
      void'(exp_edge_q.pop_front());
      void'(exp_q.pop_front());
    end else begin
      exp_now.valid    <= 1'b0;
      exp_now.redirect <= 1'b0;
      exp_now.done     <= 1'b0;
    end
  end

  a_strobes: assert property (@(negedge w_IssueFifoFire_1)
      {issue_valid, redirect_valid, pkt_done} == {exp_now.valid, exp_now.redirect, exp_now.done})
    else begin
      $display("FAILED at %0t: valid/redirect/done %b%b%b, expected %b%b%b", $time,
               issue_valid, redirect_valid, pkt_done, exp_now.valid, exp_now.redirect,
               exp_now.done);
      err_cnt = err_cnt + 1;
    end

  a_group: assert property (@(negedge w_IssueFifoFire_1) issue_group == exp_now.group)
    else begin
      $display("FAILED at %0t: issue group %h, expected %h", $time, issue_group,
               exp_now.group);
      err_cnt = err_cnt + 1;
    end

  a_redirect_pc: assert property (@(negedge w_IssueFifoFire_1) redirect_pc == exp_now.pc)
    else begin
      $display("FAILED at %0t: redirect pc %h, expected %h", $time, redirect_pc, exp_now.pc);
      err_cnt = err_cnt + 1;
    end

  function automatic logic [`BD_XLEN-1:0] rand_val();
    logic [`BD_XLEN-1:0] v;
    case ($urandom_range(0, 3))
      0: v = 32'h8000_0000;
      1: v = 32'h7fff_ffff;
      2: v = $urandom_range(0, 3);
      default: v = $urandom;
    endcase
    return v;
  endfunction

  function automatic logic [`BD_DEP_W-1:0] rand_tag();
    logic [`BD_DEP_W-1:0] t;
    t = $urandom_range(0, 14);
    if ($urandom_range(0, 1) == 0) begin
      t = DEP_NONE;
    end
    return t;
  endfunction

  // reference compare with operands picked per side by tag
  function automatic logic ref_taken(input inst_t in, input opnd_t g, input opnd_t b);
    int   l;
    int   r;
    logic t;
    l = (in.dep_l == DEP_NONE) ? g.left : b.left;
    r = (in.dep_r == DEP_NONE) ? g.right : b.right;
    case (in.cond)
      BR_EQ:   t = (l == r);
      BR_NE:   t = (l != r);
      BR_LT:   t = (l < r);
      BR_GE:   t = (l >= r);
      BR_JAL:  t = 1'b1;
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  function automatic logic [`BD_XLEN-1:0] ref_target(input inst_t in);
    int off;
    off = $signed(in.imm);
    return in.pc + off;
  endfunction

  function automatic packet_t keep_slots(input packet_t p, input int lo, input int hi);
    packet_t grp;
    grp = '0;
    for (int i = lo; i <= hi; i++) begin
      grp[i] = p[i];
    end
    return grp;
  endfunction

  task automatic push_group(input int edge_no, input packet_t grp, input logic redir,
                            input logic [`BD_XLEN-1:0] pc, input logic done);
    issue_exp_t e;
    e.valid    = 1'b1;
    e.group    = grp;
    e.redirect = redir;
    e.pc       = pc;
    e.done     = done;
    exp_edge_q.push_back(edge_no);
    exp_q.push_back(e);
  endtask

  // groups end at each branch until the first taken one, then an optional tail
  task automatic predict_packet(input packet_t p, input opnd_pkt_t g, input opnd_pkt_t b,
                                input int first_edge);
    int   start;
    int   n;
    logic taken;
    logic ended;
    start = 0;
    n     = 0;
    ended = 1'b0;
    for (int i = 0; i < `BD_SLOTS; i++) begin
      if (!ended && (p[i].opcode == OP_BJP)) begin
        taken = ref_taken(p[i], g[i], b[i]);
        push_group(first_edge + n, keep_slots(p, start, i), taken,
                   taken ? ref_target(p[i]) : 32'd0, taken || (i == `BD_SLOTS - 1));
        n     = n + 1;
        start = i + 1;
        ended = taken;
      end
    end
    if (!ended && (start < `BD_SLOTS)) begin
      push_group(first_edge + n, keep_slots(p, start, `BD_SLOTS - 1), 1'b0, 32'd0, 1'b1);
    end
  endtask

  task automatic fill_plain(input logic [`BD_XLEN-1:0] base);
    for (int s = 0; s < `BD_SLOTS; s++) begin
      pkt_v[s].opcode = opcode_e'(s % 3);
      pkt_v[s].cond   = br_cond_e'($urandom_range(0, 4));
      pkt_v[s].dep_l  = rand_tag();
      pkt_v[s].dep_r  = rand_tag();
      pkt_v[s].pc     = base + 4 * s;
      pkt_v[s].imm    = $urandom;
      grf_v[s]        = {rand_val(), rand_val()};
      byp_v[s]        = {rand_val(), rand_val()};
    end
  endtask

  task automatic place_branch(input int slot, input br_cond_e cond,
                              input logic [`BD_DEP_W-1:0] dl, input logic [`BD_DEP_W-1:0] dr,
                              input opnd_t g, input opnd_t b, input logic [`BD_IMM_W-1:0] imm);
    pkt_v[slot].opcode = OP_BJP;
    pkt_v[slot].cond   = cond;
    pkt_v[slot].dep_l  = dl;
    pkt_v[slot].dep_r  = dr;
    pkt_v[slot].imm    = imm;
    grf_v[slot]        = g;
    byp_v[slot]        = b;
  endtask

  // called on a falling edge so the strobe is sampled at the next rising edge
  task automatic send_packet();
    pkt_valid = 1'b1;
    pkt       = pkt_v;
    grf_opnd  = grf_v;
    byp_opnd  = byp_v;
    predict_packet(pkt_v, grf_v, byp_v, cyc + 4);
    @(negedge w_IssueFifoFire_1);
    pkt_valid = 1'b0;
    repeat (PKT_GAP - 1) @(negedge w_IssueFifoFire_1);
  endtask

  // slot 3 branch with chosen tags and operand sources
  task automatic send_source_case(input br_cond_e cond, input logic [`BD_DEP_W-1:0] dl,
                                  input logic [`BD_DEP_W-1:0] dr, input opnd_t g, input opnd_t b);
    fill_plain(32'h0000_4000);
    place_branch(3, cond, dl, dr, g, b, 16'h0040);
    send_packet();
  endtask

  task automatic finish_test(input string name);
    repeat (2) @(negedge w_IssueFifoFire_1);
    test_cnt = test_cnt + 1;
    if (err_cnt == err_mark) begin
      $display("test %s: pass", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("test %s: %0d check failures", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    pkt_valid = 1'b0;
    pkt       = '0;
    grf_opnd  = '0;
    byp_opnd  = '0;
    pkt_v     = '0;
    grf_v     = '0;
    byp_v     = '0;
    void'($urandom(49));
    wait (rstn === 1'b1);
    repeat (3) @(negedge w_IssueFifoFire_1);

    fill_plain(32'h0000_1000);
    send_packet();
    finish_test("reset_and_no_branch");

    fill_plain(32'h0000_2000);
    place_branch(0, BR_NE, DEP_NONE, DEP_NONE, {32'd5, 32'd5}, {32'd1, 32'd2}, 16'h0010);
    place_branch(4, BR_EQ, DEP_NONE, DEP_NONE, {32'd5, 32'd6}, {32'd1, 32'd1}, 16'h0010);
    place_branch(5, BR_LT, DEP_NONE, DEP_NONE, {32'd9, 32'd3}, {32'd1, 32'd2}, 16'h0010);
    send_packet();
    fill_plain(32'h0000_2100);
    place_branch(2, BR_EQ, DEP_NONE, DEP_NONE, {32'd1, 32'd2}, {32'd3, 32'd3}, 16'h0020);
    place_branch(7, BR_GE, DEP_NONE, DEP_NONE, {-32'sd1, 32'd0}, {32'd3, 32'd3}, 16'h0020);
    send_packet();
    fill_plain(32'h0000_2200);
    for (int s = 0; s < `BD_SLOTS; s++) begin
      place_branch(s, BR_LT, DEP_NONE, DEP_NONE, {32'd9, 32'd3}, {32'd0, 32'd7}, 16'h0004);
    end
    send_packet();
    finish_test("not_taken_groups");

    fill_plain(32'h0000_3000);
    place_branch(1, BR_EQ, DEP_NONE, DEP_NONE, {32'd1, 32'd2}, {32'd0, 32'd0}, 16'h0100);
    place_branch(3, BR_NE, DEP_NONE, DEP_NONE, {32'd1, 32'd2}, {32'd0, 32'd0}, 16'hfff0);
    place_branch(6, BR_JAL, DEP_NONE, DEP_NONE, {32'd0, 32'd0}, {32'd0, 32'd0}, 16'h0008);
    send_packet();
    fill_plain(32'h0000_3100);
    place_branch(0, BR_JAL, 4'd1, 4'd2, {32'd0, 32'd0}, {32'd0, 32'd0}, 16'h0120);
    send_packet();
    fill_plain(32'h0000_3200);
    place_branch(7, BR_JAL, DEP_NONE, DEP_NONE, {32'd0, 32'd0}, {32'd0, 32'd0}, 16'h8000);
    send_packet();
    finish_test("first_taken_redirect");

    send_source_case(BR_EQ, DEP_NONE, DEP_NONE, {32'd5, 32'd5}, {32'd5, 32'd9});
    send_source_case(BR_EQ, DEP_NONE, 4'd2, {32'd5, 32'd5}, {32'd5, 32'd9});
    send_source_case(BR_EQ, 4'd7, DEP_NONE, {32'd5, 32'd5}, {32'd6, 32'd5});
    send_source_case(BR_EQ, 4'd3, DEP_NONE, {32'd5, 32'd6}, {32'd6, 32'd0});
    send_source_case(BR_LT, DEP_NONE, DEP_NONE, {32'h8000_0000, 32'h7fff_ffff},
                     {32'h7fff_ffff, 32'h8000_0000});
    send_source_case(BR_LT, 4'd0, 4'd0, {32'h8000_0000, 32'h7fff_ffff},
                     {32'h7fff_ffff, 32'h8000_0000});
    send_source_case(BR_GE, DEP_NONE, DEP_NONE, {32'hffff_ffff, 32'd0}, {32'd0, 32'd0});
    send_source_case(BR_GE, DEP_NONE, 4'd5, {32'h8000_0000, 32'd0},
                     {32'd0, 32'h8000_0000});
    finish_test("operand_source");

    for (int k = 0; k < RAND_PKTS; k++) begin
      fill_plain($urandom);
      for (int s = 0; s < `BD_SLOTS; s++) begin
        pkt_v[s].opcode = opcode_e'($urandom_range(0, 3));
      end
      send_packet();
    end
    finish_test("random_packets");

    $display("summary: %0d tests, %0d failed, %0d check failures", test_cnt, fail_cnt,
             err_cnt);
    if ((err_cnt == 0) && (fail_cnt == 0)) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
logic/branch_pkg.sv
logic/branch_scan.sv
logic/branch_resolve.sv
logic/branch_walker.sv
logic/issue_group_builder.sv
logic/branch_detect_top.sv
tb/tb_clock_gen.sv
tb/branch_detect_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= branch_detect_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
